//--- include/proc_settings.svh
// Core-wide sizing and fixed addresses
//   data and address width, register count
//   trap vector and reset PC
`ifndef PROC_SETTINGS_SVH
`define PROC_SETTINGS_SVH

// Datapath and address bus width
`define PROC_DATA_W 16

// Architectural registers R0..R7
`define PROC_NUM_REGS 8

// Illegal opcodes vector here
`define PROC_TRAP_VEC 16'h0002

// First fetch address out of reset
`define PROC_RESET_PC 16'h0000

`endif

//--- design/procIsaPkg.sv
// Instruction set encodings
//   opcode and function-code enums
//   instruction field positions and widths
package procIsaPkg;

   // Major opcode in inst[15:11]
   typedef enum logic [4:0] {
      OP_HALT  = 5'b00000,
      OP_NOP   = 5'b00001,
      OP_RTI   = 5'b00011,
      OP_J     = 5'b00100,
      OP_ADDI  = 5'b01000,
      OP_SUBI  = 5'b01001,
      OP_BEQZ  = 5'b01100,
      OP_BNEZ  = 5'b01101,
      OP_ST    = 5'b10000,
      OP_LD    = 5'b10001,
      OP_LBI   = 5'b11000,
      OP_RTYPE = 5'b11011
   } opcodeE;

   // R-type function code in inst[1:0]
   typedef enum logic [1:0] {
      F_ADD  = 2'b00,
      F_SUB  = 2'b01,
      F_XOR  = 2'b10,
      F_ANDN = 2'b11
   } functE;

   localparam int OPCODE_LSB  = 11;
   localparam int OPCODE_W    = 5;
   localparam int FUNCT_LSB   = 0;
   localparam int FUNCT_W     = 2;
   localparam int REG_FIELD_W = 3;  // Width of Rs, Rt, Rd
   localparam int RS_LSB      = 8;  // inst[10:8]
   localparam int RT_LSB      = 5;  // inst[7:5]
   localparam int RD_LSB      = 2;  // inst[4:2]
   localparam int IMM5_W      = 5;  // Immediates all start at bit 0
   localparam int IMM8_W      = 8;
   localparam int DISP11_W    = 11;

endpackage

//--- design/procCtrlPkg.sv
// Control word encodings
//   ALU operation, write-register select
//   immediate select and next-PC source
package procCtrlPkg;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,    // A minus B
      ALU_XOR,
      ALU_ANDN,   // A and not B
      ALU_PASSB   // B straight through, used by LBI
   } aluOpE;

   // Which instruction field names the destination
   typedef enum logic [1:0] {
      DST_RD,
      DST_RT,
      DST_RS
   } regDstE;

   typedef enum logic [1:0] {
      IMM5,
      IMM8,
      DISP11
   } immSelE;

   typedef enum logic [2:0] {
      PC_SEQ,
      PC_BRANCH,  // Target only if branch taken
      PC_JUMP,
      PC_TRAP,
      PC_EPC,
      PC_HOLD
   } pcSrcE;

endpackage

//--- design/ctrlIf.sv
// Decoded control word bundle
//   driven by the decoder, read by fetch and datapath
interface ctrlIf;

   logic                  regWrite;
   procCtrlPkg::regDstE   regDst;
   logic                  memToReg;      // Write back load data
   logic                  aluSrcImm;     // B operand is immediate
   procCtrlPkg::immSelE   immSel;
   procCtrlPkg::aluOpE    aluOp;
   logic                  memRead;
   logic                  memWrite;
   logic                  isBranch;
   logic                  branchOnZero;  // BEQZ when set, BNEZ when clear
   procCtrlPkg::pcSrcE    pcSrc;
   logic                  illegalOp;

   modport dec (
      output regWrite, regDst, memToReg, aluSrcImm, immSel, aluOp,
      output memRead, memWrite, isBranch, branchOnZero, pcSrc, illegalOp
   );

   modport dp (
      input regWrite, regDst, memToReg, aluSrcImm, immSel, aluOp,
      input isBranch, branchOnZero
   );

   modport fetch (
      input pcSrc, illegalOp
   );

endinterface

//--- design/controlDecode.sv
// Main instruction decoder
//   opcode and funct to control word
//   halt and illegal-opcode err outputs
module controlDecode (
   input  logic                rstN,
   input  procIsaPkg::opcodeE  opcode,
   input  procIsaPkg::functE   funct,
   ctrlIf.dec                  ctrl,
   output logic                halt,
   output logic                err
);

   always_comb begin
      // Defaults describe a NOP
      ctrl.regWrite     = 1'b0;
      ctrl.regDst       = procCtrlPkg::DST_RD;
      ctrl.memToReg     = 1'b0;
      ctrl.aluSrcImm    = 1'b0;
      ctrl.immSel       = procCtrlPkg::IMM5;
      ctrl.aluOp        = procCtrlPkg::ALU_ADD;
      ctrl.memRead      = 1'b0;
      ctrl.memWrite     = 1'b0;
      ctrl.isBranch     = 1'b0;
      ctrl.branchOnZero = 1'b0;
      ctrl.pcSrc        = procCtrlPkg::PC_SEQ;
      ctrl.illegalOp    = 1'b0;

      case (opcode)
         procIsaPkg::OP_HALT: ctrl.pcSrc = procCtrlPkg::PC_HOLD;
         procIsaPkg::OP_NOP: ;
         procIsaPkg::OP_RTI: ctrl.pcSrc = procCtrlPkg::PC_EPC;
         procIsaPkg::OP_J: begin
            ctrl.immSel = procCtrlPkg::DISP11;
            ctrl.pcSrc  = procCtrlPkg::PC_JUMP;
         end
         procIsaPkg::OP_ADDI, procIsaPkg::OP_SUBI: begin
            ctrl.regWrite  = 1'b1;
            ctrl.regDst    = procCtrlPkg::DST_RT;
            ctrl.aluSrcImm = 1'b1;
            ctrl.aluOp     = (opcode == procIsaPkg::OP_SUBI) ? procCtrlPkg::ALU_SUB
                                                             : procCtrlPkg::ALU_ADD;
         end
         procIsaPkg::OP_BEQZ, procIsaPkg::OP_BNEZ: begin
            ctrl.isBranch     = 1'b1;
            ctrl.branchOnZero = (opcode == procIsaPkg::OP_BEQZ);
            ctrl.immSel       = procCtrlPkg::IMM8;
            ctrl.pcSrc        = procCtrlPkg::PC_BRANCH;
         end
         procIsaPkg::OP_ST: begin
            ctrl.memWrite  = 1'b1;
            ctrl.aluSrcImm = 1'b1;  // Address is Rs + imm5
         end
         procIsaPkg::OP_LD: begin
            ctrl.memRead   = 1'b1;
            ctrl.regWrite  = 1'b1;
            ctrl.regDst    = procCtrlPkg::DST_RT;
            ctrl.memToReg  = 1'b1;
            ctrl.aluSrcImm = 1'b1;
         end
         procIsaPkg::OP_LBI: begin
            ctrl.regWrite  = 1'b1;
            ctrl.regDst    = procCtrlPkg::DST_RS;
            ctrl.aluSrcImm = 1'b1;
            ctrl.immSel    = procCtrlPkg::IMM8;
            ctrl.aluOp     = procCtrlPkg::ALU_PASSB;
         end
         procIsaPkg::OP_RTYPE: begin
            ctrl.regWrite = 1'b1;
            case (funct)
               procIsaPkg::F_ADD:  ctrl.aluOp = procCtrlPkg::ALU_ADD;
               procIsaPkg::F_SUB:  ctrl.aluOp = procCtrlPkg::ALU_SUB;
               procIsaPkg::F_XOR:  ctrl.aluOp = procCtrlPkg::ALU_XOR;
               default:            ctrl.aluOp = procCtrlPkg::ALU_ANDN;
            endcase
         end
         default: begin
            // Unknown opcode goes to the trap vector
            ctrl.illegalOp = 1'b1;
            ctrl.pcSrc     = procCtrlPkg::PC_TRAP;
         end
      endcase

      // No state changes while held in reset
      if (!rstN) begin
         ctrl.regWrite  = 1'b0;
         ctrl.memRead   = 1'b0;
         ctrl.memWrite  = 1'b0;
         ctrl.illegalOp = 1'b0;
      end
   end

   assign halt = rstN && (opcode == procIsaPkg::OP_HALT);
   assign err  = ctrl.illegalOp;

endmodule

//--- design/fetchUnit.sv
// Program counter and exception PC
//   next-PC selection for all control flow
`include "proc_settings.svh"

module fetchUnit (
   input  logic                    clk,
   input  logic                    rstN,
   ctrlIf.fetch                    ctrl,
   input  logic                    branchTaken,
   input  logic [`PROC_DATA_W-1:0] branchTarget,
   input  logic [`PROC_DATA_W-1:0] jumpTarget,
   output logic [`PROC_DATA_W-1:0] pc,
   output logic [`PROC_DATA_W-1:0] pcPlus2
);

   localparam logic [`PROC_DATA_W-1:0] PC_STEP = 2;  // Fixed 16-bit instructions

   logic [`PROC_DATA_W-1:0] epc;
   logic [`PROC_DATA_W-1:0] nextPc;

   assign pcPlus2 = pc + PC_STEP;

   always_comb begin
      case (ctrl.pcSrc)
         procCtrlPkg::PC_SEQ:    nextPc = pcPlus2;
         procCtrlPkg::PC_BRANCH: nextPc = branchTaken ? branchTarget : pcPlus2;
         procCtrlPkg::PC_JUMP:   nextPc = jumpTarget;
         procCtrlPkg::PC_TRAP:   nextPc = `PROC_TRAP_VEC;
         procCtrlPkg::PC_EPC:    nextPc = epc;     // Return from trap
         procCtrlPkg::PC_HOLD:   nextPc = pc;      // Spin on HALT
         default:                nextPc = pcPlus2;
      endcase
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc  <= `PROC_RESET_PC;
         epc <= '0;
      end else begin
         pc <= nextPc;
         if (ctrl.illegalOp) begin
            epc <= pcPlus2;  // Resume after the bad instruction
         end
      end
   end

endmodule

//--- design/regFile.sv
// Eight-entry register file
//   two combinational reads on Rs and Rt
//   destination select and write-back mux
`include "proc_settings.svh"

module regFile (
   input  logic                    clk,
   input  logic                    rstN,
   ctrlIf.dp                       ctrl,
   input  logic [`PROC_DATA_W-1:0] inst,
   input  logic [`PROC_DATA_W-1:0] aluRes,
   input  logic [`PROC_DATA_W-1:0] memData,
   output logic [`PROC_DATA_W-1:0] readData1,
   output logic [`PROC_DATA_W-1:0] readData2
);

   localparam int IDX_W = procIsaPkg::REG_FIELD_W;

   logic [`PROC_DATA_W-1:0] regs [`PROC_NUM_REGS];
   logic [IDX_W-1:0]        rsIdx;
   logic [IDX_W-1:0]        rtIdx;
   logic [IDX_W-1:0]        rdIdx;
   logic [IDX_W-1:0]        writeSel;
   logic [`PROC_DATA_W-1:0] writeData;

   assign rsIdx = inst[procIsaPkg::RS_LSB +: IDX_W];
   assign rtIdx = inst[procIsaPkg::RT_LSB +: IDX_W];
   assign rdIdx = inst[procIsaPkg::RD_LSB +: IDX_W];

   always_comb begin
      case (ctrl.regDst)
         procCtrlPkg::DST_RT: writeSel = rtIdx;  // Immediate ops and LD
         procCtrlPkg::DST_RS: writeSel = rsIdx;  // LBI
         default:             writeSel = rdIdx;
      endcase
   end

   assign writeData = ctrl.memToReg ? memData : aluRes;

   assign readData1 = regs[rsIdx];
   assign readData2 = regs[rtIdx];

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < `PROC_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (ctrl.regWrite) begin
         regs[writeSel] <= writeData;
      end
   end

endmodule

//--- design/aluUnit.sv
// Execute stage logic
//   immediate sign extension and B operand select
//   ALU operations, branch zero test, PC-relative targets
`include "proc_settings.svh"

module aluUnit (
   ctrlIf.dp                       ctrl,
   input  logic [`PROC_DATA_W-1:0] inst,
   input  logic [`PROC_DATA_W-1:0] rs,
   input  logic [`PROC_DATA_W-1:0] rt,
   input  logic [`PROC_DATA_W-1:0] pcPlus2,
   output logic [`PROC_DATA_W-1:0] aluRes,
   output logic                    branchTaken,
   output logic [`PROC_DATA_W-1:0] branchTarget,
   output logic [`PROC_DATA_W-1:0] jumpTarget
);

   localparam int W = `PROC_DATA_W;

   logic [W-1:0] imm5Ext;
   logic [W-1:0] imm8Ext;
   logic [W-1:0] disp11Ext;
   logic [W-1:0] immExt;
   logic [W-1:0] opB;
   logic         rsZero;

   // Sign extension of each immediate field
   assign imm5Ext   = {{(W - procIsaPkg::IMM5_W){inst[procIsaPkg::IMM5_W-1]}},
                       inst[procIsaPkg::IMM5_W-1:0]};
   assign imm8Ext   = {{(W - procIsaPkg::IMM8_W){inst[procIsaPkg::IMM8_W-1]}},
                       inst[procIsaPkg::IMM8_W-1:0]};
   assign disp11Ext = {{(W - procIsaPkg::DISP11_W){inst[procIsaPkg::DISP11_W-1]}},
                       inst[procIsaPkg::DISP11_W-1:0]};

   always_comb begin
      case (ctrl.immSel)
         procCtrlPkg::IMM8:   immExt = imm8Ext;
         procCtrlPkg::DISP11: immExt = disp11Ext;
         default:             immExt = imm5Ext;
      endcase
   end

   assign opB = ctrl.aluSrcImm ? immExt : rt;

   always_comb begin
      case (ctrl.aluOp)
         procCtrlPkg::ALU_ADD:   aluRes = rs + opB;
         procCtrlPkg::ALU_SUB:   aluRes = rs - opB;
         procCtrlPkg::ALU_XOR:   aluRes = rs ^ opB;
         procCtrlPkg::ALU_ANDN:  aluRes = rs & ~opB;
         procCtrlPkg::ALU_PASSB: aluRes = opB;
         default:                aluRes = '0;
      endcase
   end

   // BEQZ and BNEZ both test Rs
   assign rsZero      = (rs == '0);
   assign branchTaken = ctrl.isBranch && (ctrl.branchOnZero ? rsZero : !rsZero);

   assign branchTarget = pcPlus2 + imm8Ext;
   assign jumpTarget   = pcPlus2 + disp11Ext;

endmodule

//--- design/procTop.sv
// Processor core top level
//   decoder, fetch, register file and ALU
//   instruction and data memories are external
`include "proc_settings.svh"

module procTop (
   input  logic                    clk,
   input  logic                    rstN,
   input  logic [`PROC_DATA_W-1:0] inst,
   input  logic [`PROC_DATA_W-1:0] dataRdData,
   output logic [`PROC_DATA_W-1:0] instAddr,
   output logic [`PROC_DATA_W-1:0] dataAddr,
   output logic [`PROC_DATA_W-1:0] dataWrData,
   output logic                    dataWrEn,
   output logic                    dataRdEn,
   output logic                    halt,
   output logic                    err
);

   logic [`PROC_DATA_W-1:0] pc;
   logic [`PROC_DATA_W-1:0] pcPlus2;
   logic [`PROC_DATA_W-1:0] readData1;
   logic [`PROC_DATA_W-1:0] readData2;
   logic [`PROC_DATA_W-1:0] aluRes;
   logic [`PROC_DATA_W-1:0] branchTarget;
   logic [`PROC_DATA_W-1:0] jumpTarget;
   logic                    branchTaken;

   ctrlIf ctrlBus ();

   controlDecode uDecode (
      .rstN   (rstN),
      .opcode (procIsaPkg::opcodeE'(inst[procIsaPkg::OPCODE_LSB +: procIsaPkg::OPCODE_W])),
      .funct  (procIsaPkg::functE'(inst[procIsaPkg::FUNCT_LSB +: procIsaPkg::FUNCT_W])),
      .ctrl   (ctrlBus.dec),
      .halt   (halt),
      .err    (err)
   );

   fetchUnit uFetch (
      .clk          (clk),
      .rstN         (rstN),
      .ctrl         (ctrlBus.fetch),
      .branchTaken  (branchTaken),
      .branchTarget (branchTarget),
      .jumpTarget   (jumpTarget),
      .pc           (pc),
      .pcPlus2      (pcPlus2)
   );

   regFile uRegs (
      .clk       (clk),
      .rstN      (rstN),
      .ctrl      (ctrlBus.dp),
      .inst      (inst),
      .aluRes    (aluRes),
      .memData   (dataRdData),
      .readData1 (readData1),
      .readData2 (readData2)
   );

   aluUnit uAlu (
      .ctrl         (ctrlBus.dp),
      .inst         (inst),
      .rs           (readData1),
      .rt           (readData2),
      .pcPlus2      (pcPlus2),
      .aluRes       (aluRes),
      .branchTaken  (branchTaken),
      .branchTarget (branchTarget),
      .jumpTarget   (jumpTarget)
   );

   assign instAddr   = pc;
   assign dataAddr   = aluRes;     // Rs + imm5 for LD and ST
   assign dataWrData = readData2;  // Store data is Rt
   assign dataWrEn   = ctrlBus.memWrite;
   assign dataRdEn   = ctrlBus.memRead;

endmodule

//--- verif/proc_checker.sv
// Bound assertions for the processor core
//   reset state, sequential fetch and load strobe
//   branch and jump targets, trap entry and return, halt hold
`include "proc_settings.svh"

module procChecker (
   input logic                    clk,
   input logic                    rstN,
   input logic [`PROC_DATA_W-1:0] inst,
   input logic [`PROC_DATA_W-1:0] instAddr,
   input logic [`PROC_DATA_W-1:0] rsVal,     // Rs read port of the register file
   input logic                    dataWrEn,
   input logic                    dataRdEn,
   input logic                    halt,
   input logic                    err
);
   timeunit 1ns;
   timeprecision 100ps;

   int failCount = 0;

   logic [4:0]              op;
   logic [`PROC_DATA_W-1:0] pcNext;
   logic [`PROC_DATA_W-1:0] brNext;
   logic [`PROC_DATA_W-1:0] jTarget;
   logic [`PROC_DATA_W-1:0] epcCopy;
   logic                    isBr;
   logic                    seqOp;
   logic                    legalOp;

   assign op      = inst[15:11];
   assign pcNext  = instAddr + 16'd2;
   assign jTarget = pcNext + {{5{inst[10]}}, inst[10:0]};
   assign isBr    = (op == procIsaPkg::OP_BEQZ) || (op == procIsaPkg::OP_BNEZ);
   // Taken when the Rs zero test matches the branch sense
   assign brNext  = ((rsVal == '0) == (op == procIsaPkg::OP_BEQZ)) ?
                    pcNext + {{8{inst[7]}}, inst[7:0]} : pcNext;
   assign seqOp   = op inside {procIsaPkg::OP_NOP, procIsaPkg::OP_ADDI, procIsaPkg::OP_SUBI,
                               procIsaPkg::OP_ST, procIsaPkg::OP_LD, procIsaPkg::OP_LBI,
                               procIsaPkg::OP_RTYPE};
   assign legalOp = seqOp || isBr ||
                    (op inside {procIsaPkg::OP_HALT, procIsaPkg::OP_RTI, procIsaPkg::OP_J});

   // Own copy of the return address, taken from the ports
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         epcCopy <= '0;
      end else if (!legalOp) begin
         epcCopy <= pcNext;
      end
   end

   task automatic countFailure(input string msg);
      failCount++;
      $error("%s", msg);
   endtask

   resetIdle: assert property (@(posedge clk)
      (!rstN || $rose(rstN)) |-> (instAddr == `PROC_RESET_PC) && !dataWrEn && !halt && !err)
      else countFailure("Core left the reset PC or raised an output during reset");
   readEnable: assert property (@(posedge clk)
      dataRdEn == (rstN && (op == procIsaPkg::OP_LD)))
      else countFailure("dataRdEn does not follow the fetched LD");
   seqFetch: assert property (@(posedge clk) disable iff (!rstN)
      rstN && seqOp |=> instAddr == $past(pcNext))
      else countFailure("Sequential instruction did not advance the PC by 2");
   branchNext: assert property (@(posedge clk) disable iff (!rstN)
      rstN && isBr |=> instAddr == $past(brNext))
      else countFailure("Branch went to the wrong next address");
   jumpNext: assert property (@(posedge clk) disable iff (!rstN)
      rstN && (op == procIsaPkg::OP_J) |=> instAddr == $past(jTarget))
      else countFailure("Jump went to the wrong target");
   errFlag: assert property (@(posedge clk) disable iff (!rstN)
      err == !legalOp)
      else countFailure("err does not match the legality of the fetched opcode");
   trapEntry: assert property (@(posedge clk) disable iff (!rstN)
      rstN && !legalOp |=> instAddr == `PROC_TRAP_VEC)
      else countFailure("Illegal opcode did not reach the trap vector");
   rtiReturn: assert property (@(posedge clk) disable iff (!rstN)
      rstN && (op == procIsaPkg::OP_RTI) |=> instAddr == $past(epcCopy))
      else countFailure("RTI did not return past the illegal instruction");
   haltHold: assert property (@(posedge clk) disable iff (!rstN)
      rstN && halt |=> halt && (instAddr == $past(instAddr)))
      else countFailure("Core left the halted state");

endmodule

//--- verif/procTb.sv
// Processor core testbench
//   clock, reset, program assembler with reference model
//   instruction and data memory models, store scoreboard
//   watchdog and final report
`include "proc_settings.svh"

module procTb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [15:0] MAIN_PC = 16'h0010;
   localparam int          BOOT_IDX = `PROC_RESET_PC >> 1;

   logic        clk;
   logic        rstN;
   logic [15:0] inst;
   logic [15:0] dataRdData;
   logic [15:0] instAddr;
   logic [15:0] dataAddr;
   logic [15:0] dataWrData;
   logic        dataWrEn;
   logic        dataRdEn;
   logic        halt;
   logic        err;

   logic [15:0] imem [256];
   logic [15:0] dmem [256];
   logic [15:0] refMem [256];   // Memory as the program expects it
   logic [15:0] refRegs [8];
   logic [31:0] stQ [$];        // {address, data} in program order
   logic [15:0] asmPc;
   logic [15:0] bootWord;       // Program word at the reset PC
   logic        progReady = 1'b0;
   int          instCount = 0;
   int          sbErrors = 0;
   int          otherErrors = 0;
   int          total;

   procTop DUT (
      .clk        (clk),
      .rstN       (rstN),
      .inst       (inst),
      .dataRdData (dataRdData),
      .instAddr   (instAddr),
      .dataAddr   (dataAddr),
      .dataWrData (dataWrData),
      .dataWrEn   (dataWrEn),
      .dataRdEn   (dataRdEn),
      .halt       (halt),
      .err        (err)
   );

   bind procTop procChecker uChecker (
      .clk      (clk),
      .rstN     (rstN),
      .inst     (inst),
      .instAddr (instAddr),
      .rsVal    (readData1),
      .dataWrEn (dataWrEn),
      .dataRdEn (dataRdEn),
      .halt     (halt),
      .err      (err)
   );

   // Word-addressed memories, combinational reads
   assign inst       = imem[instAddr[8:1]];
   assign dataRdData = dataRdEn ? dmem[dataAddr[8:1]] : 'x;  // Valid only while reading

   always @(posedge clk) begin
      if (rstN && dataWrEn) begin
         dmem[dataAddr[8:1]] = dataWrData;
      end
   end

   always @(negedge clk) begin
      if (rstN && dataWrEn) begin
         checkStore();
      end
   end

   task automatic checkStore();
      logic [31:0] exp;
      if (stQ.size() == 0) begin
         sbErrors++;
         $display("Store to address %h when no store was expected", dataAddr);
      end else begin
         exp = stQ.pop_front();
         addrOk: assert (dataAddr == exp[31:16]) else begin
            sbErrors++;
            $display("ERROR dataAddr got %h expected %h", dataAddr, exp[31:16]);
         end
         dataOk: assert (dataWrData == exp[15:0]) else begin
            sbErrors++;
            $display("ERROR dataWrData got %h expected %h", dataWrData, exp[15:0]);
         end
      end
   endtask

   function automatic logic [15:0] sext5(input logic [4:0] v);
      return {{11{v[4]}}, v};
   endfunction

   task automatic put(input logic [15:0] word);
      imem[asmPc[8:1]] = word;
      asmPc = asmPc + 16'd2;
      instCount++;
   endtask

   task automatic lbi(input logic [2:0] rs, input logic [7:0] imm);
      put({procIsaPkg::OP_LBI, rs, imm});
      refRegs[rs] = {{8{imm[7]}}, imm};
   endtask

   task automatic rtype(input logic [1:0] f, input logic [2:0] rs, rt, rd);
      logic [15:0] a;
      logic [15:0] b;
      a = refRegs[rs];
      b = refRegs[rt];
      put({procIsaPkg::OP_RTYPE, rs, rt, rd, f});
      case (f)
         2'b00:   refRegs[rd] = a + b;
         2'b01:   refRegs[rd] = a - b;
         2'b10:   refRegs[rd] = a ^ b;
         default: refRegs[rd] = a & ~b;
      endcase
   endtask

   task automatic immOp(input logic sub, input logic [2:0] rs, rt, input logic [4:0] imm);
      put({sub ? procIsaPkg::OP_SUBI : procIsaPkg::OP_ADDI, rs, rt, imm});
      refRegs[rt] = sub ? refRegs[rs] - sext5(imm) : refRegs[rs] + sext5(imm);
   endtask

   task automatic ld(input logic [2:0] rs, rt, input logic [4:0] imm);
      logic [15:0] addr;
      addr = refRegs[rs] + sext5(imm);
      put({procIsaPkg::OP_LD, rs, rt, imm});
      refRegs[rt] = refMem[addr[8:1]];
   endtask

   task automatic st(input logic [2:0] rs, rt, input logic [4:0] imm);
      logic [15:0] addr;
      addr = refRegs[rs] + sext5(imm);
      put({procIsaPkg::OP_ST, rs, rt, imm});
      refMem[addr[8:1]] = refRegs[rt];
      stQ.push_back({addr, refRegs[rt]});
   endtask

   // Store to base-2 that is never expected
   task automatic wrongPath();
      put({procIsaPkg::OP_ST, 3'd7, 3'd0, 5'd30});
   endtask

   task automatic branchOverStore(input logic onZero, input logic [2:0] rs);
      logic taken;
      taken = onZero ? (refRegs[rs] == 16'h0) : (refRegs[rs] != 16'h0);
      put({onZero ? procIsaPkg::OP_BEQZ : procIsaPkg::OP_BNEZ, rs, 8'd2});
      if (taken) begin
         wrongPath();
      end else begin
         st(3'd7, 3'd6, 5'd8);
      end
   endtask

   task automatic buildProgram();
      asmPc = `PROC_RESET_PC;
      put({procIsaPkg::OP_J, 11'(MAIN_PC - `PROC_RESET_PC - 16'd2)});
      asmPc = `PROC_TRAP_VEC;        // Trap handler
      put({procIsaPkg::OP_NOP, 11'd0});
      put({procIsaPkg::OP_RTI, 11'd0});
      asmPc = MAIN_PC;
      lbi(3'd7, 8'h40);               // Base address for loads and stores
      for (int r = 0; r < 6; r++) begin
         lbi(3'(r), 8'($urandom));
      end
      st(3'd7, 3'd0, 5'd0);
      for (int f = 0; f < 4; f++) begin
         rtype(2'(f), 3'(f), 3'(f + 1), 3'd6);
         st(3'd7, 3'd6, 5'(2 * f + 2));
      end
      immOp(1'b0, 3'd1, 3'd6, 5'($urandom));
      st(3'd7, 3'd6, 5'd10);
      immOp(1'b1, 3'd2, 3'd6, 5'($urandom));
      st(3'd7, 3'd6, 5'd12);
      ld(3'd7, 3'd6, 5'h10);          // Preloaded word below the base
      st(3'd7, 3'd6, 5'd14);
      ld(3'd7, 3'd5, 5'h1e);
      st(3'd7, 3'd5, 5'd14);
      ld(3'd7, 3'd4, 5'd4);           // Reads back an earlier store
      st(3'd7, 3'd4, 5'h18);
      lbi(3'd4, 8'h00);
      lbi(3'd5, 8'h81);
      branchOverStore(1'b1, 3'd4);
      branchOverStore(1'b1, 3'd5);
      branchOverStore(1'b0, 3'd5);
      branchOverStore(1'b0, 3'd4);
      put({procIsaPkg::OP_J, 11'd2});
      wrongPath();
      put({5'b11111, 11'h000});       // Unassigned opcode
      st(3'd7, 3'd5, 5'd6);
      put({procIsaPkg::OP_HALT, 11'd0});
   endtask

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial begin
      wait (progReady);
      #(instCount * 400);
      $display("Watchdog timeout before the core reached HALT");
      $display("Simulation failed");
      $finish;
   end

   initial begin
      rstN = 1'b0;
      void'($urandom(32'h519a));
      for (int i = 0; i < 256; i++) begin
         dmem[i] = 16'($urandom);
         refMem[i] = dmem[i];
      end
      buildProgram();
      progReady = 1'b1;
      bootWord = imem[BOOT_IDX];
      imem[BOOT_IDX] = {procIsaPkg::OP_HALT, 11'd0};  // Reset masks halt
      @(posedge clk);
      #1 imem[BOOT_IDX] = {procIsaPkg::OP_ST, 3'd0, 3'd0, 5'd0};  // and the store strobe
      @(posedge clk);
      #1;
      imem[BOOT_IDX] = bootWord;
      rstN = 1'b1;
      wait (halt === 1'b1);
      repeat (4) @(posedge clk);
      if (stQ.size() != 0) begin
         otherErrors++;
         $display("%0d expected stores were never seen", stQ.size());
      end
      total = sbErrors + otherErrors + DUT.uChecker.failCount;
      $display("Errors: scoreboard %0d, checker %0d, other %0d",
               sbErrors, DUT.uChecker.failCount, otherErrors);
      if (total == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- tb.f
+incdir+include
design/procIsaPkg.sv
design/procCtrlPkg.sv
design/ctrlIf.sv
design/controlDecode.sv
design/fetchUnit.sv
design/regFile.sv
design/aluUnit.sv
design/procTop.sv
verif/proc_checker.sv
verif/procTb.sv

//--- run.sh
#!/bin/sh
# Build and run the processor testbench with Verilator
set -e

verilator --binary --top-module procTb -f tb.f

# Keep running after assertion errors so the testbench prints its report
./obj_dir/VprocTb +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
   exit 1
fi
